/* hw/lsu_pkg.sv */
// lsu package
// shared data-format encoding and address / memory sizing constants
// for the load/store path

package lsu_pkg;

  // byte address width seen by the core
  localparam int ADDR_W = 32;

  // data word width, four byte lanes
  localparam int DATA_W = 32;

  // memory depth in 32-bit words
  localparam int MEM_WORDS = 256;

  // word index width, address bits 9..2 with the default depth
  localparam int WORD_ADDR_W = $clog2(MEM_WORDS);

  // RISC-V funct3 width encoding for loads and stores
  // bit 2 set means zero extension on loads
  typedef enum logic [2:0] {
    fmt_byte   = 3'b000,
    fmt_half   = 3'b001,
    fmt_word   = 3'b010,
    fmt_byte_u = 3'b100,
    fmt_half_u = 3'b101
  } data_format_t;

  // 011, 110 and 111 are left unnamed and are treated as invalid

endpackage

/* hw/data_bus_if.sv */
// data bus between the access pipeline and the word RAM
// word address, write strobe with byte enables, write and read data

`timescale 1ns/1ps

interface data_bus_if;

  // word index, low two byte-address bits already stripped
  logic [lsu_pkg::WORD_ADDR_W-1:0] word_address;
  logic                            write_enable;
  // one enable per byte lane
  logic [3:0]                      byte_enable;
  logic [lsu_pkg::DATA_W-1:0]      write_data;
  // combinational read of word_address
  logic [lsu_pkg::DATA_W-1:0]      read_data;

  // pipeline side
  modport master (
    output word_address,
    output write_enable,
    output byte_enable,
    output write_data,
    input  read_data
  );

  // RAM side
  modport memory (
    input  word_address,
    input  write_enable,
    input  byte_enable,
    input  write_data,
    output read_data
  );

endinterface

/* hw/data_memory_interface.sv */
// data memory interface
// places store data on its byte lanes and forms byte enables,
// shifts load data down and sign- or zero-extends it

`timescale 1ns/1ps

module data_memory_interface (
  input  logic [lsu_pkg::ADDR_W-1:0] address,
  input  lsu_pkg::data_format_t      data_format,
  input  logic [lsu_pkg::DATA_W-1:0] write_data,
  input  logic [lsu_pkg::DATA_W-1:0] bus_read_data,
  output logic [lsu_pkg::DATA_W-1:0] bus_write_data,
  output logic [3:0]                 bus_byte_enable,
  output logic [lsu_pkg::DATA_W-1:0] read_data
);

  // byte offset inside the word
  logic [1:0] offset;
  // shift amount in bits, offset times eight
  logic [4:0] bit_shift;
  // raw format code, bit 2 picks zero extension
  logic [2:0] fmt_code;
  logic       zero_ext;

  assign offset    = address[1:0];
  assign bit_shift = {offset, 3'b000};
  assign fmt_code  = data_format;
  assign zero_ext  = fmt_code[2];

  // store data moves up to its lanes
  assign bus_write_data = write_data << bit_shift;

  // byte enables
  always_comb begin
    case (data_format)
      lsu_pkg::fmt_byte,
      lsu_pkg::fmt_byte_u: bus_byte_enable = 4'b0001 << offset;
      lsu_pkg::fmt_half,
      lsu_pkg::fmt_half_u: bus_byte_enable = 4'b0011 << offset;
      lsu_pkg::fmt_word:   bus_byte_enable = 4'b1111 << offset;
      // unknown code, no lanes
      default:             bus_byte_enable = 4'b0000;
    endcase
  end

  // load alignment and extension
  always_comb begin
    logic [lsu_pkg::DATA_W-1:0] shifted;
    logic                       fill;
    // bring the addressed lane down to bit 0
    shifted = bus_read_data >> bit_shift;
    fill    = 1'b0;
    case (data_format)
      lsu_pkg::fmt_byte,
      lsu_pkg::fmt_byte_u: begin
        // lb copies bit 7, lbu fills zeros
        fill      = ~zero_ext & shifted[7];
        read_data = {{24{fill}}, shifted[7:0]};
      end
      lsu_pkg::fmt_half,
      lsu_pkg::fmt_half_u: begin
        // lh copies bit 15, lhu fills zeros
        fill      = ~zero_ext & shifted[15];
        read_data = {{16{fill}}, shifted[15:0]};
      end
      lsu_pkg::fmt_word: begin
        read_data = shifted;
      end
      default: begin
        // dropped as an error upstream, drive zeros
        read_data = '0;
      end
    endcase
  end

endmodule

/* hw/data_memory.sv */
// data memory
// word-organized RAM with per-byte write enables,
// combinational read and a clocked write

`timescale 1ns/1ps

module data_memory (
  input  logic       clock,
  input  logic       rst,
  data_bus_if.memory bus
);

  // storage, contents undefined until written
  logic [lsu_pkg::DATA_W-1:0] mem [lsu_pkg::MEM_WORDS];

  // write each enabled lane at the edge
  always_ff @(posedge clock) begin
    if (bus.write_enable) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus.byte_enable[lane]) begin
          mem[bus.word_address][8*lane +: 8] <= bus.write_data[8*lane +: 8];
        end
      end
    end
  end

  // read is same-cycle on word_address
  // a store at this edge is visible to the next cycle's read
  assign bus.read_data = mem[bus.word_address];

  // lanes must be resolved on every write cycle
  // the pipeline computes them from the registered format and address
  a_byte_enable_known : assert property (
    @(posedge clock) disable iff (rst)
      bus.write_enable |-> !$isunknown(bus.byte_enable)
  ) else $error("data_memory: byte_enable unknown during write");

  // address must also be known when writing
  a_word_address_known : assert property (
    @(posedge clock) disable iff (rst)
      bus.write_enable |-> !$isunknown(bus.word_address)
  ) else $error("data_memory: word_address unknown during write");

endmodule

/* hw/mem_access_pipeline.sv */
// memory access pipeline
// stage one registers the core request, checks alignment and format
// and drives the data bus; stage two registers the load result

`timescale 1ns/1ps

module mem_access_pipeline (
  input  logic                       clock,
  input  logic                       rst,
  input  logic                       req_valid,
  input  logic                       req_write,
  input  logic [lsu_pkg::ADDR_W-1:0] req_address,
  input  lsu_pkg::data_format_t      req_format,
  input  logic [lsu_pkg::DATA_W-1:0] req_write_data,
  output logic                       read_valid,
  output logic [lsu_pkg::DATA_W-1:0] read_data,
  output logic                       access_error,
  data_bus_if.master                 bus
);

  // stage one request
  logic                       s1_valid;
  logic                       s1_write;
  logic [lsu_pkg::ADDR_W-1:0] s1_address;
  lsu_pkg::data_format_t      s1_format;
  logic [lsu_pkg::DATA_W-1:0] s1_write_data;

  // stage one decode
  logic                       format_ok;
  logic                       misaligned;
  logic                       legal;
  logic [lsu_pkg::DATA_W-1:0] load_data;

  // control part of stage one
  always_ff @(posedge clock) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid;
    end
  end

  // payload, only meaningful while s1_valid
  always_ff @(posedge clock) begin
    s1_write      <= req_write;
    s1_address    <= req_address;
    s1_format     <= req_format;
    s1_write_data <= req_write_data;
  end

  // format validity and alignment
  always_comb begin
    format_ok  = 1'b0;
    misaligned = 1'b0;
    case (s1_format)
      lsu_pkg::fmt_byte,
      lsu_pkg::fmt_byte_u: begin
        format_ok = 1'b1;
      end
      lsu_pkg::fmt_half,
      lsu_pkg::fmt_half_u: begin
        format_ok  = 1'b1;
        misaligned = s1_address[0];
      end
      lsu_pkg::fmt_word: begin
        format_ok  = 1'b1;
        misaligned = (s1_address[1:0] != 2'b00);
      end
      default: begin
        format_ok = 1'b0;
      end
    endcase
  end

  // no lane wrap, bad requests are dropped
  assign legal = format_ok & ~misaligned;

  // bus control from stage one
  assign bus.word_address = s1_address[lsu_pkg::WORD_ADDR_W+1:2];
  assign bus.write_enable = s1_valid & s1_write & legal;

  // lane placement and load extension
  data_memory_interface u_data_memory_interface (
    .address         (s1_address),
    .data_format     (s1_format),
    .write_data      (s1_write_data),
    .bus_read_data   (bus.read_data),
    .bus_write_data  (bus.write_data),
    .bus_byte_enable (bus.byte_enable),
    .read_data       (load_data)
  );

  // stage two, flags are one-cycle pulses
  always_ff @(posedge clock) begin
    if (rst) begin
      read_valid   <= 1'b0;
      access_error <= 1'b0;
    end else begin
      read_valid   <= s1_valid & ~s1_write & legal;
      access_error <= s1_valid & ~legal;
    end
  end

  // load data held until the next load
  always_ff @(posedge clock) begin
    if (s1_valid && !s1_write) begin
      read_data <= load_data;
    end
  end

  // a write always hits at least one lane
  a_write_has_lanes : assert property (
    @(posedge clock) disable iff (rst)
      bus.write_enable |-> (bus.byte_enable != 4'b0000)
  ) else $error("mem_access_pipeline: write with no byte enable");

endmodule

/* hw/lsu_top.sv */
// load/store unit top
// two-stage access pipeline in front of a byte-enabled data RAM,
// joined by the data bus interface

`timescale 1ns/1ps

module lsu_top (
  input  logic                       clock,
  input  logic                       rst,
  // core request strobe
  input  logic                       req_valid,
  input  logic                       req_write,
  input  logic [lsu_pkg::ADDR_W-1:0] req_address,
  input  lsu_pkg::data_format_t      req_format,
  input  logic [lsu_pkg::DATA_W-1:0] req_write_data,
  // load response, two edges after the request
  output logic                       read_valid,
  output logic [lsu_pkg::DATA_W-1:0] read_data,
  output logic                       access_error
);

  // pipeline to RAM
  data_bus_if bus ();

  // request and response registers
  mem_access_pipeline u_mem_access_pipeline (
    .clock          (clock),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_address    (req_address),
    .req_format     (req_format),
    .req_write_data (req_write_data),
    .read_valid     (read_valid),
    .read_data      (read_data),
    .access_error   (access_error),
    .bus            (bus.master)
  );

  // backing store
  data_memory u_data_memory (
    .clock (clock),
    .rst   (rst),
    .bus   (bus.memory)
  );

endmodule

/* tests/lsu_tb.sv */
// lsu testbench
// replays the vector file through the load/store path, then runs seeded
// random word traffic checked against a model of the RAM

`timescale 1ns/1ps

module lsu_tb;

  // random word operations after the file vectors
  localparam int RAND_COUNT = 64;
  // random traffic stays in words 0x80..0xbf, clear of the vector addresses
  localparam int RAND_BASE = 128;
  localparam int RAND_SPAN = 64;

  logic                       clock = 1'b0;
  logic                       rst;
  logic                       req_valid;
  logic                       req_write;
  logic [lsu_pkg::ADDR_W-1:0] req_address;
  lsu_pkg::data_format_t      req_format;
  logic [lsu_pkg::DATA_W-1:0] req_write_data;
  logic                       read_valid;
  logic [lsu_pkg::DATA_W-1:0] read_data;
  logic                       access_error;

  // vectors from the data file
  logic        vec_write[$];
  logic [2:0]  vec_format[$];
  logic [31:0] vec_address[$];
  logic [31:0] vec_store[$];
  logic [31:0] vec_load[$];
  logic        vec_error[$];

  // expected responses, one entry per request cycle
  logic        exp_valid_q[$];
  logic        exp_error_q[$];
  logic [31:0] exp_data_q[$];

  // RAM model for the random phase
  logic [31:0] model_mem [lsu_pkg::MEM_WORDS];
  logic        model_written [lsu_pkg::MEM_WORDS];

  integer seed;
  int     cycles = 0;
  int     cycle_limit;
  int     errors;

  // 100 ns period
  always #50 clock = ~clock;

  lsu_top u_lsu_top (
    .clock          (clock),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_address    (req_address),
    .req_format     (req_format),
    .req_write_data (req_write_data),
    .read_valid     (read_valid),
    .read_data      (read_data),
    .access_error   (access_error)
  );

  // run limit, armed once the vector count is known
  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH time %0t %s actual %h expected %h",
               $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "first mismatch");
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    int          w;
    int          f;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    int          err;
    fd = $fopen("tests/lsu_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/lsu_testdata.txt");
      $display("Errors found");
      $fatal(1, "no test data");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip comments and blank lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%d %h %h %h %h %d", w, f, a, d, e, err);
        if (n != 6) begin
          $display("test data line could not be parsed: %s", line);
          $display("Errors found");
          $fatal(1, "bad test data");
        end
        vec_write.push_back(w != 0);
        vec_format.push_back(f[2:0]);
        vec_address.push_back(a);
        vec_store.push_back(d);
        vec_load.push_back(e);
        vec_error.push_back(err != 0);
      end
    end
    $fclose(fd);
  endtask

  // oldest queued response is due now
  task automatic check_oldest();
    logic        ev;
    logic        ee;
    logic [31:0] ed;
    ev = exp_valid_q.pop_front();
    ee = exp_error_q.pop_front();
    ed = exp_data_q.pop_front();
    check_value("read_valid", 32'(read_valid), 32'(ev));
    check_value("access_error", 32'(access_error), 32'(ee));
    // data only matters on a good load
    if (ev) begin
      check_value("read_data", read_data, ed);
    end
  endtask

  // one request per cycle, response checked two edges later
  task automatic issue(input logic write, input logic [2:0] fmt,
                       input logic [31:0] addr, input logic [31:0] data,
                       input logic ev, input logic ee, input logic [31:0] ed);
    @(posedge clock);
    #5;
    if (exp_valid_q.size() == 2) begin
      check_oldest();
    end
    req_valid      = 1'b1;
    req_write      = write;
    req_format     = lsu_pkg::data_format_t'(fmt);
    req_address    = addr;
    req_write_data = data;
    exp_valid_q.push_back(ev);
    exp_error_q.push_back(ee);
    exp_data_q.push_back(ed);
  endtask

  // aligned word stores and reloads of already written words
  task automatic random_traffic();
    int          r;
    int          idx;
    logic        store;
    logic [31:0] addr;
    logic [31:0] data;
    for (r = 0; r < RAND_COUNT; r++) begin
      idx   = RAND_BASE + int'($unsigned($random(seed)) % RAND_SPAN);
      store = (($random(seed) % 2) != 0) || !model_written[idx];
      addr  = {22'd0, idx[7:0], 2'b00};
      if (store) begin
        data = $random(seed);
        model_mem[idx]     = data;
        model_written[idx] = 1'b1;
        issue(1'b1, 3'b010, addr, data, 1'b0, 1'b0, 32'd0);
      end else begin
        issue(1'b0, 3'b010, addr, 32'd0, 1'b1, 1'b0, model_mem[idx]);
      end
    end
  endtask

  initial begin
    int v;
    seed           = 57;
    errors         = 0;
    cycle_limit    = 0;
    rst            = 1'b1;
    req_valid      = 1'b0;
    req_write      = 1'b0;
    req_address    = '0;
    req_format     = lsu_pkg::fmt_byte;
    req_write_data = '0;
    for (v = 0; v < lsu_pkg::MEM_WORDS; v++) begin
      model_written[v] = 1'b0;
    end
    load_vectors();
    if (vec_write.size() == 0) begin
      $display("test data file holds no vectors");
      $display("Errors found");
      $fatal(1, "empty test data");
    end
    cycle_limit = 2 * vec_write.size() + RAND_COUNT + 20;
    repeat (3) @(posedge clock);
    #5;
    rst = 1'b0;
    // file vectors, back to back
    for (v = 0; v < vec_write.size(); v++) begin
      issue(vec_write[v], vec_format[v], vec_address[v], vec_store[v],
            !vec_write[v] && !vec_error[v], vec_error[v], vec_load[v]);
    end
    random_traffic();
    // drain the last two responses
    while (exp_valid_q.size() > 0) begin
      @(posedge clock);
      #5;
      check_oldest();
      req_valid = 1'b0;
    end
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tests/lsu_testdata.txt */
# columns: write format address store_data expected_load error (hex except write/error)
# format: 0 byte, 1 half, 2 word, 4 byte unsigned, 5 half unsigned, 3 6 7 invalid
# word store then word load of the same address, back to back
1 2 00000010 12345678 00000000 0
0 2 00000010 00000000 12345678 0
# address bits above bit 9 are ignored
0 2 00000410 00000000 12345678 0
# byte lanes merge into one word, upper store bits masked off
1 2 00000020 11223344 00000000 0
1 0 00000020 ffffffa0 00000000 0
0 2 00000020 00000000 112233a0 0
1 0 00000021 abcdefb1 00000000 0
1 4 00000022 000000c2 00000000 0
1 0 00000023 123456d3 00000000 0
0 2 00000020 00000000 d3c2b1a0 0
# byte loads, bit 7 set in every lane
0 0 00000020 00000000 ffffffa0 0
0 4 00000020 00000000 000000a0 0
0 0 00000021 00000000 ffffffb1 0
0 4 00000021 00000000 000000b1 0
0 0 00000022 00000000 ffffffc2 0
0 4 00000022 00000000 000000c2 0
0 0 00000023 00000000 ffffffd3 0
0 4 00000023 00000000 000000d3 0
# half loads
0 1 00000020 00000000 ffffb1a0 0
0 5 00000020 00000000 0000b1a0 0
0 1 00000022 00000000 ffffd3c2 0
0 5 00000022 00000000 0000d3c2 0
# mixed sign bytes 7f 80 01 7e
1 2 00000030 7f80017e 00000000 0
0 0 00000030 00000000 0000007e 0
0 0 00000031 00000000 00000001 0
0 0 00000032 00000000 ffffff80 0
0 0 00000033 00000000 0000007f 0
0 1 00000030 00000000 0000017e 0
0 1 00000032 00000000 00007f80 0
# half store into the upper lanes
1 2 00000040 55555555 00000000 0
1 1 00000042 9999beef 00000000 0
0 5 00000042 00000000 0000beef 0
0 1 00000042 00000000 ffffbeef 0
# misaligned and invalid formats, nothing written
1 1 00000041 0000dead 00000000 1
1 2 00000042 deadbeef 00000000 1
1 2 00000043 deadbeef 00000000 1
1 3 00000040 deadbeef 00000000 1
1 6 00000040 deadbeef 00000000 1
0 1 00000023 00000000 00000000 1
0 2 00000021 00000000 00000000 1
0 7 00000020 00000000 00000000 1
0 2 00000040 00000000 beef5555 0

/* src.f */
hw/lsu_pkg.sv
hw/data_bus_if.sv
hw/data_memory_interface.sv
hw/data_memory.sv
hw/mem_access_pipeline.sv
hw/lsu_top.sv
tests/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
  --top-module lsu_tb -f src.f -o lsu_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/lsu_sim > "$LOG" 2>&1
cat "$LOG"

grep -qx "No errors" "$LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
